/* hdl/kiwi_pkg.sv */
// widths, register map and bit positions shared by the control block
// word addresses only, no byte lanes on the bus
package kiwi_pkg;

    // bus widths
    typedef logic [3:0]  wb_adr_t;
    typedef logic [15:0] wb_data_t;

    // register and counter widths
    typedef logic [13:0] ctrl_t;
    typedef logic [31:0] ctr_t;

    ////////////////////
    // register map
    ////////////////////
    localparam wb_adr_t ADR_CTRL     = 4'd0;
    localparam wb_adr_t ADR_STATUS   = 4'd1;
    localparam wb_adr_t ADR_CTR_CMD  = 4'd2;
    localparam wb_adr_t ADR_CTR0_LO  = 4'd3;
    localparam wb_adr_t ADR_CTR0_HI  = 4'd4;
    localparam wb_adr_t ADR_CTR1_LO  = 4'd5;
    localparam wb_adr_t ADR_CTR1_HI  = 4'd6;
    localparam wb_adr_t ADR_SRQ      = 4'd7;
    localparam wb_adr_t ADR_OVFL_CLR = 4'd8;

    ////////////////////
    // control bits
    ////////////////////
    // serial select lives in the two low bits
    localparam int CTRL_SER_SEL_LSB = 0;
    localparam int CTRL_SER_LE_CSN  = 2;
    localparam int CTRL_SER_CLK     = 3;
    localparam int CTRL_SER_DATA    = 4;
    localparam int CTRL_OSC_DIS     = 5;
    localparam int CTRL_STEN        = 6;
    localparam int CTRL_EEPROM_WP   = 7;
    localparam int CTRL_CMD_READY   = 8;
    localparam int CTRL_SND_INTR    = 9;

    // counter command word
    localparam int CMD_CTR_CLR = 0;
    localparam int CMD_CTR_ENA = 1;
    localparam int CMD_CTR_DIS = 2;

    // status word
    localparam int STAT_OVFL    = 15;
    localparam int STAT_VER_LSB = 8;
    localparam int STAT_DNA     = 4;
    localparam int STAT_ID_LSB  = 0;

    // serial line target
    typedef enum logic [1:0] {SER_NONE, SER_ATTN, SER_GPS, SER_DNA} ser_sel_e;

endpackage

/* hdl/ctrl_regs.sv */
// global control register; outputs follow the register with no extra delay
// only one serial target sees the bit-bang lines, the others are held low
`timescale 1ns/1ps

module ctrl_regs (
    input  logic               cpu_clk,
    input  logic               rx_orst,
    input  logic               ctrl_wr,
    input  kiwi_pkg::wb_data_t wb_dat_w,
    output kiwi_pkg::ctrl_t    ctrl,
    output logic               da_dale,
    output logic               da_daclk,
    output logic               da_dadat,
    output logic               gps_gscs,
    output logic               gps_gsclk,
    output logic               gps_gsdat,
    output logic               dna_read,
    output logic               dna_clk,
    output logic               dna_shift,
    output logic               adc_clken,
    output logic               adc_stenl,
    output logic               ewp,
    output logic               cmd_ready,
    output logic               snd_intr
);

    kiwi_pkg::ser_sel_e ser_sel;
    // {data, clk, le/csn} as written
    logic [2:0]         ser_bits;

    ////////////////////
    // register
    ////////////////////
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (ctrl_wr)
            ctrl <= wb_dat_w[$bits(kiwi_pkg::ctrl_t)-1:0];
    end

    ////////////////////
    // serial steering
    ////////////////////
    assign ser_sel  = kiwi_pkg::ser_sel_e'(ctrl[kiwi_pkg::CTRL_SER_SEL_LSB +: 2]);
    assign ser_bits = {ctrl[kiwi_pkg::CTRL_SER_DATA],
                       ctrl[kiwi_pkg::CTRL_SER_CLK],
                       ctrl[kiwi_pkg::CTRL_SER_LE_CSN]};

    // attenuator
    assign {da_dadat, da_daclk, da_dale} = {3{ser_sel == kiwi_pkg::SER_ATTN}} & ser_bits;
    // gps front end
    assign {gps_gsdat, gps_gsclk, gps_gscs} = {3{ser_sel == kiwi_pkg::SER_GPS}} & ser_bits;
    // device id shifter, le doubles as read
    assign {dna_shift, dna_clk, dna_read} = {3{ser_sel == kiwi_pkg::SER_DNA}} & ser_bits;

    ////////////////////
    // board pins
    ////////////////////
    // enable and self-test pins are active low on the board
    assign adc_clken = ~ctrl[kiwi_pkg::CTRL_OSC_DIS];
    assign adc_stenl = ~ctrl[kiwi_pkg::CTRL_STEN];
    assign ewp       = ctrl[kiwi_pkg::CTRL_EEPROM_WP];
    assign cmd_ready = ctrl[kiwi_pkg::CTRL_CMD_READY];
    assign snd_intr  = ctrl[kiwi_pkg::CTRL_SND_INTR];

endmodule

/* hdl/dna_shifter.sv */
// behavioral stand-in for the device-id port, loads a fixed DNA_VALUE
// a control level is seen one cycle late and acted on one cycle after that
`timescale 1ns/1ps

module dna_shifter #(
    parameter int                  DNA_BITS  = 57,
    parameter logic [DNA_BITS-1:0] DNA_VALUE = 57'h1C3_A5E7_F9B2_D46
) (
    input  logic cpu_clk,
    input  logic rx_orst,
    input  logic dna_read,
    input  logic dna_clk,
    input  logic dna_shift,
    output logic dna_data
);

    // bit 1 is read-and-clock, bit 0 is shift-and-clock
    logic [1:0]          lvl_now;
    logic [1:0]          lvl_prev;
    logic [1:0]          pulse;
    logic [DNA_BITS-1:0] id_sr;

    ////////////////////
    // level to single pulse
    ////////////////////
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            lvl_now  <= '0;
            lvl_prev <= '0;
        end
        else
        begin
            lvl_now  <= {dna_read & dna_clk, dna_shift & dna_clk};
            lvl_prev <= lvl_now;
        end
    end

    // rising edge only, one cycle wide
    assign pulse = lvl_now & ~lvl_prev;

    ////////////////////
    // id shift register
    ////////////////////
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            id_sr <= '0;
        else if (pulse[1])
            id_sr <= DNA_VALUE;
        // shifts toward the top, ones fill from below
        else if (pulse[0])
            id_sr <= {id_sr[DNA_BITS-2:0], 1'b1};
    end

    // msb first out
    assign dna_data = id_sr[DNA_BITS-1];

endmodule

/* hdl/cycle_counters.sv */
// two 32-bit cycle counters; counter 1 starts disabled
// the high-half snapshot is shared, last low-half read wins
`timescale 1ns/1ps

module cycle_counters (
    input  logic               cpu_clk,
    input  logic               rx_orst,
    input  logic               cmd_wr,
    input  kiwi_pkg::wb_data_t wb_dat_w,
    input  logic               ctr0_lo_rd,
    input  logic               ctr1_lo_rd,
    output kiwi_pkg::ctr_t     ctr0,
    output kiwi_pkg::wb_data_t ctr1_lo,
    output kiwi_pkg::wb_data_t ctr_hi_snap,
    output kiwi_pkg::wb_data_t ctr1_hi_live
);

    kiwi_pkg::ctr_t ctr1;
    logic           ctr1_ena;

    ////////////////////
    // counters and commands
    ////////////////////
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctr0     <= '0;
            ctr1     <= '0;
            ctr1_ena <= 1'b0;
        end
        else
        begin
            // counter 0 free-running, counter 1 gated
            ctr0 <= ctr0 + 32'd1;
            if (ctr1_ena)
                ctr1 <= ctr1 + 32'd1;
            // later statements win, so clear then enable then disable
            if (cmd_wr && wb_dat_w[kiwi_pkg::CMD_CTR_CLR])
            begin
                ctr0 <= '0;
                ctr1 <= '0;
            end
            if (cmd_wr && wb_dat_w[kiwi_pkg::CMD_CTR_ENA])
                ctr1_ena <= 1'b1;
            if (cmd_wr && wb_dat_w[kiwi_pkg::CMD_CTR_DIS])
                ctr1_ena <= 1'b0;
        end
    end

    // high half frozen at the low-half read
    always_ff @(posedge cpu_clk)
    begin
        if (ctr0_lo_rd)
            ctr_hi_snap <= ctr0[31:16];
        else if (ctr1_lo_rd)
            ctr_hi_snap <= ctr1[31:16];
    end

    assign ctr1_lo      = ctr1[15:0];
    assign ctr1_hi_live = ctr1[31:16];

endmodule

/* hdl/event_latches.sv */
// sticky adc overflow and host service-request latch
// both inputs must already be on cpu_clk
`timescale 1ns/1ps

module event_latches (
    input  logic cpu_clk,
    input  logic rx_orst,
    input  logic adc_ovfl,
    input  logic host_srq,
    input  logic ovfl_clr,
    input  logic srq_rd,
    output logic ovfl_sticky,
    output logic srq_noted
);

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ovfl_sticky <= 1'b0;
            srq_noted   <= 1'b0;
        end
        else
        begin
            // overflow arriving with the clear is kept
            if (ovfl_clr)
                ovfl_sticky <= adc_ovfl;
            else
                ovfl_sticky <= ovfl_sticky | adc_ovfl;
            // read takes the old value, a new request survives the clear
            if (srq_rd)
                srq_noted <= host_srq;
            else
                srq_noted <= srq_noted | host_srq;
        end
    end

endmodule

/* hdl/wb_slave_port.sv */
// wishbone classic slave, one wait state, ack for a single cycle
// strobes are combinational and act on the edge where ack rises
`timescale 1ns/1ps

module wb_slave_port #(
    parameter logic [3:0] FPGA_VER = 4'd1,
    parameter logic [3:0] FPGA_ID  = 4'd2
) (
    input  logic               cpu_clk,
    input  logic               rx_orst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  kiwi_pkg::wb_adr_t  wb_adr,
    input  kiwi_pkg::wb_data_t wb_dat_w,
    input  kiwi_pkg::ctrl_t    ctrl,
    input  logic               ovfl_sticky,
    input  logic               srq_noted,
    input  logic               dna_data,
    input  kiwi_pkg::ctr_t     ctr0,
    input  kiwi_pkg::wb_data_t ctr1_lo,
    input  kiwi_pkg::wb_data_t ctr_hi_snap,
    input  kiwi_pkg::wb_data_t ctr1_hi_live,
    output kiwi_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               ctrl_wr,
    output logic               cmd_wr,
    output logic               ovfl_clr,
    output logic               ctr0_lo_rd,
    output logic               ctr1_lo_rd,
    output logic               srq_rd
);

    logic               access;
    logic               wr_acc;
    logic               rd_acc;
    // which counter owns the shared snapshot, {ctr1, ctr0}
    logic [1:0]         snap_own;
    kiwi_pkg::wb_data_t status;
    kiwi_pkg::wb_data_t rd_mux;

    ////////////////////
    // handshake
    ////////////////////
    // first cycle of a transfer only
    assign access = wb_cyc & wb_stb & ~wb_ack;
    assign wr_acc = access & wb_we;
    assign rd_acc = access & ~wb_we;

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    // write strobes
    assign ctrl_wr  = wr_acc && (wb_adr == kiwi_pkg::ADR_CTRL);
    assign cmd_wr   = wr_acc && (wb_adr == kiwi_pkg::ADR_CTR_CMD);
    assign ovfl_clr = wr_acc && (wb_adr == kiwi_pkg::ADR_OVFL_CLR);

    // read side effects
    assign ctr0_lo_rd = rd_acc && (wb_adr == kiwi_pkg::ADR_CTR0_LO);
    assign ctr1_lo_rd = rd_acc && (wb_adr == kiwi_pkg::ADR_CTR1_LO);
    assign srq_rd     = rd_acc && (wb_adr == kiwi_pkg::ADR_SRQ);

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            snap_own <= 2'b00;
        else if (ctr0_lo_rd)
            snap_own <= 2'b01;
        else if (ctr1_lo_rd)
            snap_own <= 2'b10;
    end

    ////////////////////
    // read mux
    ////////////////////
    always_comb
    begin
        status = '0;
        status[kiwi_pkg::STAT_OVFL]       = ovfl_sticky;
        status[kiwi_pkg::STAT_VER_LSB +: 4] = FPGA_VER;
        status[kiwi_pkg::STAT_DNA]        = dna_data;
        status[kiwi_pkg::STAT_ID_LSB +: 4]  = FPGA_ID;
    end

    always_comb
    begin
        rd_mux = '0;
        case (wb_adr)
            kiwi_pkg::ADR_CTRL:    rd_mux = kiwi_pkg::wb_data_t'(ctrl);
            kiwi_pkg::ADR_STATUS:  rd_mux = status;
            kiwi_pkg::ADR_CTR0_LO: rd_mux = ctr0[15:0];
            // high half without its low read gives the live value
            kiwi_pkg::ADR_CTR0_HI: rd_mux = snap_own[0] ? ctr_hi_snap : ctr0[31:16];
            kiwi_pkg::ADR_CTR1_LO: rd_mux = ctr1_lo;
            kiwi_pkg::ADR_CTR1_HI: rd_mux = snap_own[1] ? ctr_hi_snap : ctr1_hi_live;
            kiwi_pkg::ADR_SRQ:     rd_mux = kiwi_pkg::wb_data_t'(srq_noted);
            default:               rd_mux = '0;
        endcase
    end

    // held while ack is high
    always_ff @(posedge cpu_clk)
    begin
        if (rd_acc)
            wb_dat_r <= rd_mux;
    end

endmodule

/* hdl/kiwi_ctrl_top.sv */
// control and status block of the receiver, all on cpu_clk
// adc_ovfl and host_srq must be synchronous to cpu_clk
`timescale 1ns/1ps

module kiwi_ctrl_top #(
    parameter logic [3:0]          FPGA_VER  = 4'd1,
    parameter logic [3:0]          FPGA_ID   = 4'd2,
    parameter int                  DNA_BITS  = 57,
    parameter logic [DNA_BITS-1:0] DNA_VALUE = 57'h1C3_A5E7_F9B2_D46
) (
    input  logic               cpu_clk,
    input  logic               rx_orst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  kiwi_pkg::wb_adr_t  wb_adr,
    input  kiwi_pkg::wb_data_t wb_dat_w,
    input  logic               adc_ovfl,
    input  logic               host_srq,
    output kiwi_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               adc_clken,
    output logic               adc_stenl,
    output logic               da_dale,
    output logic               da_daclk,
    output logic               da_dadat,
    output logic               gps_gscs,
    output logic               gps_gsclk,
    output logic               gps_gsdat,
    output logic               ewp,
    output logic               cmd_ready,
    output logic               snd_intr
);

    // bus strobes
    logic               ctrl_wr;
    logic               cmd_wr;
    logic               ovfl_clr;
    logic               ctr0_lo_rd;
    logic               ctr1_lo_rd;
    logic               srq_rd;
    // read sources
    kiwi_pkg::ctrl_t    ctrl;
    logic               ovfl_sticky;
    logic               srq_noted;
    logic               dna_data;
    kiwi_pkg::ctr_t     ctr0;
    kiwi_pkg::wb_data_t ctr1_lo;
    kiwi_pkg::wb_data_t ctr_hi_snap;
    kiwi_pkg::wb_data_t ctr1_hi_live;
    // gated id lines
    logic               dna_read;
    logic               dna_clk;
    logic               dna_shift;

    ////////////////////
    // bus port
    ////////////////////
    wb_slave_port #(
        .FPGA_VER (FPGA_VER),
        .FPGA_ID  (FPGA_ID)
    ) wb_slave_port_i (
        .cpu_clk      (cpu_clk),
        .rx_orst      (rx_orst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .ctrl         (ctrl),
        .ovfl_sticky  (ovfl_sticky),
        .srq_noted    (srq_noted),
        .dna_data     (dna_data),
        .ctr0         (ctr0),
        .ctr1_lo      (ctr1_lo),
        .ctr_hi_snap  (ctr_hi_snap),
        .ctr1_hi_live (ctr1_hi_live),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .ctrl_wr      (ctrl_wr),
        .cmd_wr       (cmd_wr),
        .ovfl_clr     (ovfl_clr),
        .ctr0_lo_rd   (ctr0_lo_rd),
        .ctr1_lo_rd   (ctr1_lo_rd),
        .srq_rd       (srq_rd)
    );

    ////////////////////
    // control and pins
    ////////////////////
    ctrl_regs ctrl_regs_i (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .ctrl_wr   (ctrl_wr),
        .wb_dat_w  (wb_dat_w),
        .ctrl      (ctrl),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .dna_read  (dna_read),
        .dna_clk   (dna_clk),
        .dna_shift (dna_shift),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    dna_shifter #(
        .DNA_BITS  (DNA_BITS),
        .DNA_VALUE (DNA_VALUE)
    ) dna_shifter_i (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .dna_read  (dna_read),
        .dna_clk   (dna_clk),
        .dna_shift (dna_shift),
        .dna_data  (dna_data)
    );

    ////////////////////
    // counters and events
    ////////////////////
    cycle_counters cycle_counters_i (
        .cpu_clk      (cpu_clk),
        .rx_orst      (rx_orst),
        .cmd_wr       (cmd_wr),
        .wb_dat_w     (wb_dat_w),
        .ctr0_lo_rd   (ctr0_lo_rd),
        .ctr1_lo_rd   (ctr1_lo_rd),
        .ctr0         (ctr0),
        .ctr1_lo      (ctr1_lo),
        .ctr_hi_snap  (ctr_hi_snap),
        .ctr1_hi_live (ctr1_hi_live)
    );

    event_latches event_latches_i (
        .cpu_clk     (cpu_clk),
        .rx_orst     (rx_orst),
        .adc_ovfl    (adc_ovfl),
        .host_srq    (host_srq),
        .ovfl_clr    (ovfl_clr),
        .srq_rd      (srq_rd),
        .ovfl_sticky (ovfl_sticky),
        .srq_noted   (srq_noted)
    );

endmodule

/* test/tb_kiwi_ref.svh */
// bus tasks and expected-value functions, included inside tb_kiwi_ctrl
// every task starts 5 ns after a rising edge and returns at the same offset
`ifndef TB_KIWI_REF_SVH
`define TB_KIWI_REF_SVH

////////////////////
// bus access
////////////////////
// one classic cycle, held until ack is seen
task automatic bus_cycle(input logic we, input kiwi_pkg::wb_adr_t adr,
                         input kiwi_pkg::wb_data_t wdat, output kiwi_pkg::wb_data_t rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(posedge cpu_clk);
    #5;
    while (wb_ack !== 1'b1)
    begin
        @(posedge cpu_clk);
        #5;
    end
    // read data valid while ack is high
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic write_reg(input kiwi_pkg::wb_adr_t adr, input kiwi_pkg::wb_data_t wdat);
    kiwi_pkg::wb_data_t unused;
    bus_cycle(1'b1, adr, wdat, unused);
endtask

task automatic read_reg(input kiwi_pkg::wb_adr_t adr, output kiwi_pkg::wb_data_t rdat);
    bus_cycle(1'b0, adr, 16'h0000, rdat);
endtask

// low half first, high half sits at the next address
task automatic read_counter(input kiwi_pkg::wb_adr_t lo_adr, output logic [31:0] val);
    kiwi_pkg::wb_data_t lo;
    kiwi_pkg::wb_data_t hi;
    read_reg(lo_adr, lo);
    read_reg(lo_adr + 4'd1, hi);
    val = {hi, lo};
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(posedge cpu_clk);
    #5;
endtask

////////////////////
// expected values
////////////////////
// 14 control bits stored, top two read as zero
function automatic logic [15:0] ctrl_readback(input logic [15:0] wdat);
    return {2'b00, wdat[13:0]};
endfunction

// {attn le clk data, gps cs clk data, clken, stenl, ewp, cmd_ready, snd_intr}
function automatic logic [10:0] pin_levels(input logic [15:0] c);
    logic [2:0] ser;
    logic [2:0] attn;
    logic [2:0] gps;
    ser  = {c[kiwi_pkg::CTRL_SER_LE_CSN], c[kiwi_pkg::CTRL_SER_CLK], c[kiwi_pkg::CTRL_SER_DATA]};
    attn = (c[1:0] == 2'd1) ? ser : 3'b000;
    gps  = (c[1:0] == 2'd2) ? ser : 3'b000;
    // oscillator and self-test pins are inverted
    return {attn, gps, ~c[kiwi_pkg::CTRL_OSC_DIS], ~c[kiwi_pkg::CTRL_STEN],
            c[kiwi_pkg::CTRL_EEPROM_WP], c[kiwi_pkg::CTRL_CMD_READY], c[kiwi_pkg::CTRL_SND_INTR]};
endfunction

function automatic logic [15:0] status_word(input logic ovfl, input logic dna);
    return {ovfl, 3'b000, FPGA_VER, 3'b000, dna, FPGA_ID};
endfunction

// id bit seen after n shifts, msb first, ones past the end
function automatic logic dna_bit_after(input int n);
    if (n >= DNA_BITS)
        return 1'b1;
    return DNA_VALUE[DNA_BITS-1-n];
endfunction

`endif

/* test/tb_kiwi_ctrl.sv */
// drives kiwi_ctrl_top with inputs changing 5 ns after each rising edge
// counter high halves stay zero over this run so wrap is not reached
`timescale 1ns/1ps

module tb_kiwi_ctrl;

    localparam logic [3:0]          FPGA_VER    = 4'h5;
    localparam logic [3:0]          FPGA_ID     = 4'hA;
    localparam int                  DNA_BITS    = 57;
    localparam logic [DNA_BITS-1:0] DNA_VALUE   = {1'b1, 56'hB6D4_2F9A_53C8_E7};
    localparam int                  TIMEOUT_CYC = 3000;
    // compare kinds
    localparam int CMP_EQ = 0;
    localparam int CMP_GT = 1;
    localparam int CMP_LE = 2;

    logic               cpu_clk = 1'b0;
    logic               rx_orst;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    kiwi_pkg::wb_adr_t  wb_adr;
    kiwi_pkg::wb_data_t wb_dat_w;
    kiwi_pkg::wb_data_t wb_dat_r;
    logic               wb_ack;
    logic               adc_ovfl;
    logic               host_srq;
    logic               adc_clken;
    logic               adc_stenl;
    logic               da_dale;
    logic               da_daclk;
    logic               da_dadat;
    logic               gps_gscs;
    logic               gps_gsclk;
    logic               gps_gsdat;
    logic               ewp;
    logic               cmd_ready;
    logic               snd_intr;
    logic [10:0]        pins;

    // pending checks for the compare process
    string       chk_name_q[$];
    int          chk_kind_q[$];
    logic [31:0] chk_exp_q[$];
    logic [31:0] chk_act_q[$];
    event        chk_ev;
    int          n_checks = 0;
    int          n_errors = 0;
    int          chk_base = 0;
    int          err_base = 0;
    int          cyc_cnt  = 0;
    logic        ack_last = 1'b0;
    logic        stb_last = 1'b0;

    `include "tb_kiwi_ref.svh"

    kiwi_ctrl_top #(
        .FPGA_VER  (FPGA_VER),
        .FPGA_ID   (FPGA_ID),
        .DNA_BITS  (DNA_BITS),
        .DNA_VALUE (DNA_VALUE)
    ) kiwi_ctrl_top_i (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .adc_ovfl  (adc_ovfl),
        .host_srq  (host_srq),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    // same order as pin_levels
    assign pins = {da_dale, da_daclk, da_dadat, gps_gscs, gps_gsclk, gps_gsdat,
                   adc_clken, adc_stenl, ewp, cmd_ready, snd_intr};

    // 100 ns period
    always #50 cpu_clk = ~cpu_clk;

    task automatic queue_check(input string name, input int kind,
                               input logic [31:0] exp, input logic [31:0] act);
        chk_name_q.push_back(name);
        chk_kind_q.push_back(kind);
        chk_exp_q.push_back(exp);
        chk_act_q.push_back(act);
        -> chk_ev;
    endtask

    // lets the compare process drain before the report
    task automatic finish_test(input string name);
        #1;
        $display("test %s done: %0d checks, %0d errors", name,
                 n_checks - chk_base, n_errors - err_base);
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    ////////////////////
    // compare
    ////////////////////
    always
    begin : compare
        string       nm;
        int          kind;
        logic [31:0] e;
        logic [31:0] a;
        @(chk_ev);
        while (chk_exp_q.size() > 0)
        begin
            nm   = chk_name_q.pop_front();
            kind = chk_kind_q.pop_front();
            e    = chk_exp_q.pop_front();
            a    = chk_act_q.pop_front();
            n_checks++;
            case (kind)
                CMP_EQ:
                begin
                    assert (a === e)
                    else
                    begin
                        $display("ERR %s expected 0x%h actual 0x%h", nm, e, a);
                        n_errors++;
                    end
                end
                CMP_GT:
                begin
                    assert (a > e)
                    else
                    begin
                        $display("ERR %s expected above 0x%h actual 0x%h", nm, e, a);
                        n_errors++;
                    end
                end
                default:
                begin
                    assert (a <= e)
                    else
                    begin
                        $display("ERR %s expected at most 0x%h actual 0x%h", nm, e, a);
                        n_errors++;
                    end
                end
            endcase
        end
    end

    // ack may only follow a strobe that the slave saw on the edge before
    always @(negedge cpu_clk)
    begin
        if (!rx_orst)
        begin
            assert (!(wb_ack && !ack_last && !stb_last))
            else
            begin
                $display("wb_ack rose although wb_stb was low");
                n_errors++;
            end
        end
        ack_last <= wb_ack;
        stb_last <= wb_stb;
    end

    // run limit well beyond the test length
    always @(posedge cpu_clk)
    begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC)
        begin
            $display("timeout: tests still running after %0d cycles", cyc_cnt);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial
    begin : stimulus
        kiwi_pkg::wb_data_t rd;
        kiwi_pkg::wb_data_t wdat;
        logic [31:0]        v0;
        logic [31:0]        v1;
        logic [31:0]        prev;
        int                 seed;
        seed     = 93372;
        rx_orst  = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        adc_ovfl = 1'b0;
        host_srq = 1'b0;
        repeat (16) @(posedge cpu_clk);
        #5;
        rx_orst = 1'b0;

        // status word with the id register still clear from reset
        read_reg(kiwi_pkg::ADR_STATUS, rd);
        queue_check("wb_dat_r status", CMP_EQ, status_word(1'b0, 1'b0), rd);
        adc_ovfl = 1'b1;
        idle_cycles(1);
        adc_ovfl = 1'b0;
        read_reg(kiwi_pkg::ADR_STATUS, rd);
        queue_check("wb_dat_r status", CMP_EQ, status_word(1'b1, 1'b0), rd);
        // sticky
        idle_cycles(6);
        read_reg(kiwi_pkg::ADR_STATUS, rd);
        queue_check("wb_dat_r status", CMP_EQ, status_word(1'b1, 1'b0), rd);
        write_reg(kiwi_pkg::ADR_OVFL_CLR, 16'h0000);
        read_reg(kiwi_pkg::ADR_STATUS, rd);
        queue_check("wb_dat_r status", CMP_EQ, status_word(1'b0, 1'b0), rd);
        finish_test("status");

        // service request cleared by its read
        read_reg(kiwi_pkg::ADR_SRQ, rd);
        queue_check("wb_dat_r srq", CMP_EQ, 32'h0, rd);
        host_srq = 1'b1;
        idle_cycles(1);
        host_srq = 1'b0;
        read_reg(kiwi_pkg::ADR_SRQ, rd);
        queue_check("wb_dat_r srq", CMP_EQ, 32'h1, rd);
        read_reg(kiwi_pkg::ADR_SRQ, rd);
        queue_check("wb_dat_r srq", CMP_EQ, 32'h0, rd);
        finish_test("srq");

        // control register and pin steering
        read_reg(kiwi_pkg::ADR_CTRL, rd);
        queue_check("wb_dat_r ctrl", CMP_EQ, 32'h0, rd);
        queue_check("pins", CMP_EQ, pin_levels(16'h0000), pins);
        for (int i = 0; i < 8; i++)
        begin
            wdat = $random(seed);
            write_reg(kiwi_pkg::ADR_CTRL, wdat);
            queue_check("pins", CMP_EQ, pin_levels(wdat), pins);
            read_reg(kiwi_pkg::ADR_CTRL, rd);
            queue_check("wb_dat_r ctrl", CMP_EQ, ctrl_readback(wdat), rd);
        end
        finish_test("ctrl");

        // id lines dropped first so the load sees a rising edge
        write_reg(kiwi_pkg::ADR_CTRL, 16'h0000);
        idle_cycles(3);
        // select id with le and clk high
        write_reg(kiwi_pkg::ADR_CTRL, 16'h000F);
        write_reg(kiwi_pkg::ADR_CTRL, 16'h0003);
        idle_cycles(3);
        for (int k = 0; k < 8; k++)
        begin
            if (k > 0)
            begin
                // one data and clk pulse per shift
                write_reg(kiwi_pkg::ADR_CTRL, 16'h001B);
                write_reg(kiwi_pkg::ADR_CTRL, 16'h0003);
                idle_cycles(3);
            end
            read_reg(kiwi_pkg::ADR_STATUS, rd);
            queue_check("wb_dat_r status", CMP_EQ, status_word(1'b0, dna_bit_after(k)), rd);
        end
        finish_test("dna");

        // clear both and keep counter 1 stopped
        write_reg(kiwi_pkg::ADR_CTR_CMD, 16'h0005);
        read_counter(kiwi_pkg::ADR_CTR1_LO, v1);
        queue_check("ctr1", CMP_EQ, 32'h0, v1);
        idle_cycles(10);
        read_counter(kiwi_pkg::ADR_CTR1_LO, v1);
        queue_check("ctr1", CMP_EQ, 32'h0, v1);
        // short run of counter 1
        write_reg(kiwi_pkg::ADR_CTR_CMD, 16'h0002);
        idle_cycles(20);
        write_reg(kiwi_pkg::ADR_CTR_CMD, 16'h0004);
        read_counter(kiwi_pkg::ADR_CTR1_LO, v1);
        read_counter(kiwi_pkg::ADR_CTR0_LO, v0);
        queue_check("ctr1 after run", CMP_GT, 32'h0, v1);
        queue_check("ctr1 against ctr0", CMP_LE, v0, v1);
        idle_cycles(5);
        read_counter(kiwi_pkg::ADR_CTR1_LO, prev);
        queue_check("ctr1", CMP_EQ, v1, prev);
        // counter 0 keeps rising across spaced reads
        prev = v0;
        for (int j = 0; j < 6; j++)
        begin
            idle_cycles(1 + ($random(seed) & 7));
            read_counter(kiwi_pkg::ADR_CTR0_LO, v0);
            queue_check("ctr0", CMP_GT, prev, v0);
            prev = v0;
        end
        finish_test("counters");

        // unmapped and write-only addresses read as zero
        read_reg(4'hF, rd);
        queue_check("wb_dat_r unmapped", CMP_EQ, 32'h0, rd);
        read_reg(4'h9, rd);
        queue_check("wb_dat_r unmapped", CMP_EQ, 32'h0, rd);
        read_reg(kiwi_pkg::ADR_CTR_CMD, rd);
        queue_check("wb_dat_r ctr_cmd", CMP_EQ, 32'h0, rd);
        read_reg(kiwi_pkg::ADR_OVFL_CLR, rd);
        queue_check("wb_dat_r ovfl_clr", CMP_EQ, 32'h0, rd);
        // cycle held open with stb low gets no ack and writes nothing
        wb_cyc   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = kiwi_pkg::ADR_CTRL;
        wb_dat_w = 16'h03E0;
        idle_cycles(4);
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        read_reg(kiwi_pkg::ADR_CTRL, rd);
        queue_check("wb_dat_r ctrl", CMP_EQ, ctrl_readback(16'h0003), rd);
        finish_test("bus");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+test
hdl/kiwi_pkg.sv
hdl/ctrl_regs.sv
hdl/dna_shifter.sv
hdl/cycle_counters.sv
hdl/event_latches.sv
hdl/wb_slave_port.sv
hdl/kiwi_ctrl_top.sv
test/tb_kiwi_ctrl.sv
